// ==== bench/dcache_tb.sv ====
`timescale 1ns/10ps

module dcache_tb;

    localparam int WORD_AW     = 12;
    localparam int MEM_WORDS   = 2 ** WORD_AW;
    localparam int WAIT_LIMIT  = 4000;
    localparam int MIX_COUNT   = 400;
    localparam int LINE_BYTES  = dcache_pkg::LINE_WORDS * dcache_pkg::WORD_BYTES;
    localparam int INDEX_SHIFT = dcache_pkg::OFFSET_BITS + dcache_pkg::ALIGN_BITS;
    localparam int TAG_SHIFT   = dcache_pkg::INDEX_BITS + INDEX_SHIFT;

    logic                clk;
    logic                resetn;
    logic                req_valid;
    logic [31:0]         req_addr;
    dcache_pkg::strobe_t req_strobe;
    dcache_pkg::word_t   req_wdata;
    logic                addr_ok;
    logic                data_ok;
    dcache_pkg::word_t   rdata;
    logic                mem_valid;
    logic                mem_write;
    logic [31:0]         mem_addr;
    dcache_pkg::word_t   mem_wdata;
    logic                mem_ready;
    logic                mem_last;
    dcache_pkg::word_t   mem_rdata;
    logic                stall_en;

    dcache_pkg::word_t   shadow [MEM_WORDS];
    dcache_pkg::word_t   exp_q [$];
    logic [31:0]         exp_addr_q [$];
    logic [31:0]         wb_lines [$];
    logic [31:0]         first_read_addr;
    logic [31:0]         addr;
    logic [31:0]         line;
    logic [31:0]         rnd;
    logic [31:0]         exp_addr;
    dcache_pkg::word_t   exp_word;
    dcache_pkg::strobe_t strobe;
    logic                accepted_prev;
    logic                in_burst;
    int                  read_bursts;
    int                  bursts_before;
    int                  checks;
    int                  errors;
    int                  tests;
    int                  checks_at_start;
    int                  errors_at_start;
    int                  waited;
    integer              seed;
    string               test_name;
    int                  mix_sets [3] = '{3, 7, 12};
    dcache_pkg::strobe_t byte_strobes [8] = '{4'b0001, 4'b0110, 4'b1000, 4'b1111,
                                              4'b0101, 4'b1010, 4'b0011, 4'b1100};

    dcache_top uut (.*);

    mem_model memory (.*);

    always #10 clk = ~clk;

    function automatic dcache_pkg::word_t pattern_word(input logic [31:0] byte_addr);
        return (byte_addr * 32'h9e3779b1) ^ {byte_addr[15:0], byte_addr[31:16]};
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int index, input int offset);
        return (32'(tag) << TAG_SHIFT) | (32'(index) << INDEX_SHIFT)
             | (32'(offset) << dcache_pkg::ALIGN_BITS);
    endfunction

    // expected word from the shadow memory
    function automatic dcache_pkg::word_t ref_read(input logic [31:0] byte_addr);
        return shadow[byte_addr[WORD_AW+1:2]];
    endfunction

    function automatic void check_equal(input string what, input logic [31:0] expected,
                                        input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s, %s: expected %h, actual %h", test_name, what, expected,
                     actual);
        end
    endfunction

    task automatic write_shadow(input logic [31:0] a, input dcache_pkg::strobe_t s,
                                input dcache_pkg::word_t d);
        for (int b = 0; b < dcache_pkg::WORD_BYTES; b++) begin
            if (s[b]) begin
                shadow[a[WORD_AW+1:2]][b*8 +: 8] = d[b*8 +: 8];
            end
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $finish;
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        checks_at_start = checks;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests++;
        $display("%s: %0d checks, %0d errors", test_name, checks - checks_at_start,
                 errors - errors_at_start);
    endtask

    // hold the request until addr_ok, then record what the read must return
    task automatic access(input logic [31:0] a, input dcache_pkg::strobe_t s,
                          input dcache_pkg::word_t d);
        req_valid  = 1'b1;
        req_addr   = a;
        req_strobe = s;
        req_wdata  = d;
        waited     = 0;
        @(negedge clk);
        while (!addr_ok && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!addr_ok) begin
            abort_run($sformatf("%s: request to %h was never accepted", test_name, a));
        end else begin
            exp_q.push_back(ref_read(a));
            exp_addr_q.push_back(a);
            write_shadow(a, s, d);
            @(posedge clk);
            #1;
            req_valid = 1'b0;
        end
    endtask

    task automatic drain();
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            abort_run($sformatf("%s: data_ok never came for %0d requests", test_name,
                                exp_q.size()));
        end else begin
            @(posedge clk);
            #1;
        end
    endtask

    // checks data_ok and rdata one cycle after each acceptance
    always @(negedge clk) begin
        if (!resetn && (accepted_prev || data_ok)) begin
            check_equal("data_ok one cycle after addr_ok", 32'(accepted_prev), 32'(data_ok));
            if (data_ok && exp_q.size() != 0) begin
                exp_word = exp_q.pop_front();
                exp_addr = exp_addr_q.pop_front();
                check_equal($sformatf("rdata at %h", exp_addr), exp_word, rdata);
            end
        end
        accepted_prev = addr_ok;
    end

    // burst monitor
    always @(negedge clk) begin
        if (mem_valid && !in_burst) begin
            in_burst = 1'b1;
            if (mem_write) begin
                wb_lines.push_back(mem_addr);
            end else begin
                read_bursts++;
                first_read_addr = mem_addr;
            end
        end
        if (mem_valid && mem_ready && mem_last) begin
            in_burst = 1'b0;
        end
    end

    initial begin
        clk             = 1'b0;
        resetn          = 1'b1;
        // a miss held through reset must not start a burst
        req_valid       = 1'b1;
        req_addr        = '0;
        req_strobe      = '0;
        req_wdata       = '0;
        stall_en        = 1'b0;
        seed            = 32'hffe;
        checks          = 0;
        errors          = 0;
        tests           = 0;
        read_bursts     = 0;
        accepted_prev   = 1'b0;
        in_burst        = 1'b0;
        first_read_addr = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = pattern_word(32'(i) << 2);
        end

        start_test("reset");
        for (int c = 0; c < 5; c++) begin
            @(negedge clk);
            check_equal("addr_ok", 0, 32'(addr_ok));
            check_equal("data_ok", 0, 32'(data_ok));
            check_equal("mem_valid", 0, 32'(mem_valid));
            if (c == 2) begin
                @(posedge clk);
                #1;
                resetn    = 1'b0;
                req_valid = 1'b0;
            end
        end
        finish_test();
        @(posedge clk);
        #1;

        start_test("cold reads");
        for (int i = 0; i < 8; i++) begin
            addr = make_addr(1, i, (i * 3) % 8);
            bursts_before = read_bursts;
            access(addr, '0, '0);
            check_equal($sformatf("read bursts for %h", addr), bursts_before + 1, read_bursts);
            check_equal("burst start address", addr, first_read_addr);
        end
        drain();
        finish_test();

        start_test("hit timing");
        bursts_before = read_bursts;
        for (int i = 0; i < 8; i++) begin
            access(make_addr(1, i, (i * 3 + 5) % 8), '0, '0);
        end
        drain();
        check_equal("read bursts during hits", bursts_before, read_bursts);
        finish_test();

        start_test("byte writes");
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            access(make_addr(1, i % 4, i), byte_strobes[i], rnd);
        end
        for (int i = 0; i < 8; i++) begin
            access(make_addr(1, i % 4, i), '0, '0);
        end
        drain();
        finish_test();

        // six dirty tags in one set of four ways
        start_test("dirty eviction");
        wb_lines.delete();
        for (int t = 2; t < 8; t++) begin
            for (int w = 0; w < 2; w++) begin
                rnd = $random(seed);
                access(make_addr(t, 9, (t + w * 3) % 8), '1, rnd);
            end
        end
        for (int t = 2; t < 8; t++) begin
            for (int w = 0; w < dcache_pkg::LINE_WORDS; w++) begin
                access(make_addr(t, 9, w), '0, '0);
            end
        end
        drain();
        check_equal("at least two write-back bursts", 1, 32'(wb_lines.size() >= 2));
        foreach (wb_lines[k]) begin
            line = wb_lines[k] & ~32'(LINE_BYTES - 1);
            for (int w = 0; w < dcache_pkg::LINE_WORDS; w++) begin
                addr = line + 32'(w * dcache_pkg::WORD_BYTES);
                check_equal($sformatf("memory word %h", addr), ref_read(addr),
                            memory.mem[addr[WORD_AW+1:2]]);
            end
        end
        finish_test();

        start_test("back-pressure");
        stall_en = 1'b1;
        for (int n = 0; n < MIX_COUNT; n++) begin
            rnd    = $random(seed);
            addr   = make_addr(8 + rnd[2:0], mix_sets[rnd[4:3] % 3], rnd[7:5]);
            strobe = rnd[8] ? rnd[12:9] : '0;
            access(addr, strobe, $random(seed));
        end
        drain();
        stall_en = 1'b0;
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== bench/mem_model.sv ====
`timescale 1ns/10ps

module mem_model (
    input  logic                             clk,
    input  logic                             stall_en,
    input  logic                             mem_valid,
    input  logic                             mem_write,
    input  logic [dcache_pkg::ADDR_BITS-1:0] mem_addr,
    input  dcache_pkg::word_t                mem_wdata,
    output logic                             mem_ready,
    output logic                             mem_last,
    output dcache_pkg::word_t                mem_rdata
);
    localparam int WORD_AW   = 12;
    localparam int STALL_PCT = 35;
    localparam int OFF_TOP   = dcache_pkg::OFFSET_BITS + 1;

    dcache_pkg::word_t  mem [2**WORD_AW];
    logic [WORD_AW-1:0] beat_addr;
    int                 beat;
    logic               fire;
    integer             seed;

    function automatic dcache_pkg::word_t fill_word(input logic [31:0] byte_addr);
        return (byte_addr * 32'h9e3779b1) ^ {byte_addr[15:0], byte_addr[31:16]};
    endfunction

    // the current beat's word wraps inside the line
    assign beat_addr = {mem_addr[WORD_AW+1:OFF_TOP+1],
                        mem_addr[OFF_TOP:2] + dcache_pkg::offset_t'(beat)};
    assign mem_rdata = mem[beat_addr];
    assign mem_last  = (beat == dcache_pkg::LINE_WORDS - 1);

    initial begin
        seed      = 32'hffe;
        beat      = 0;
        mem_ready = 1'b1;
        for (int i = 0; i < 2**WORD_AW; i++) begin
            mem[i] = fill_word(32'(i) << 2);
        end
    end

    // beat decided at the negedge and counted just after the rising edge
    always begin
        @(negedge clk);
        fire = mem_valid && mem_ready;
        if (fire && mem_write) begin
            mem[beat_addr] = mem_wdata;
        end
        @(posedge clk);
        #1;
        if (fire) begin
            beat = mem_last ? 0 : beat + 1;
        end
        mem_ready = !stall_en || ($unsigned($random(seed)) % 100 >= STALL_PCT);
    end

endmodule

// ==== dcache.f ====
hdl/dcache_pkg.sv
hdl/lookup_if.sv
hdl/tag_store.sv
hdl/plru_tree.sv
hdl/line_data_ram.sv
hdl/miss_controller.sv
hdl/dcache_top.sv
bench/mem_model.sv
bench/dcache_tb.sv

// ==== hdl/dcache_pkg.sv ====
package dcache_pkg;

    // cache geometry
    localparam int WAYS       = 4;
    localparam int SETS       = 16;
    localparam int LINE_WORDS = 8;
    localparam int WORD_BYTES = 4;
    localparam int ADDR_BITS  = 32;

    localparam int WAY_BITS      = $clog2(WAYS);
    localparam int INDEX_BITS    = $clog2(SETS);
    localparam int OFFSET_BITS   = $clog2(LINE_WORDS);
    localparam int ALIGN_BITS    = 2;
    localparam int TAG_BITS      = ADDR_BITS - INDEX_BITS - OFFSET_BITS - ALIGN_BITS;
    localparam int RAM_ADDR_BITS = WAY_BITS + INDEX_BITS + OFFSET_BITS;

    typedef logic [WORD_BYTES*8-1:0]  word_t;
    typedef logic [WORD_BYTES-1:0]    strobe_t;
    typedef logic [WAY_BITS-1:0]      way_t;
    typedef logic [INDEX_BITS-1:0]    index_t;
    typedef logic [OFFSET_BITS-1:0]   offset_t;
    typedef logic [TAG_BITS-1:0]      tag_t;

    // tree bits of one set with bit 0 at the root
    typedef logic [WAYS-2:0] plru_t;

    typedef struct packed {
        tag_t                  tag;
        index_t                index;
        offset_t               offset;
        logic [ALIGN_BITS-1:0] align;
    } addr_t;

    // word address inside the data RAM
    typedef struct packed {
        way_t    way;
        index_t  index;
        offset_t offset;
    } ram_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        WB_READ,
        WB_SEND,
        FETCH
    } ctrl_state_t;

endpackage

// ==== hdl/dcache_top.sv ====
`timescale 1ns/10ps

module dcache_top (
    input  logic                             clk,
    input  logic                             resetn,

    input  logic                             req_valid,
    input  logic [dcache_pkg::ADDR_BITS-1:0] req_addr,
    input  dcache_pkg::strobe_t              req_strobe,
    input  dcache_pkg::word_t                req_wdata,
    output logic                             addr_ok,
    output logic                             data_ok,
    output dcache_pkg::word_t                rdata,

    output logic                             mem_valid,
    output logic                             mem_write,
    output logic [dcache_pkg::ADDR_BITS-1:0] mem_addr,
    output dcache_pkg::word_t                mem_wdata,
    input  logic                             mem_ready,
    input  logic                             mem_last,
    input  dcache_pkg::word_t                mem_rdata
);
    dcache_pkg::addr_t     req_fields;
    dcache_pkg::way_t      victim_way;
    dcache_pkg::way_t      touch_way;
    logic                  touch;
    logic                  ram_en;
    dcache_pkg::strobe_t   ram_we;
    dcache_pkg::ram_addr_t ram_addr;
    dcache_pkg::word_t     ram_wdata;
    dcache_pkg::word_t     ram_rdata;

    lookup_if lk ();

    assign req_fields = req_addr;

    tag_store u_tags (
        .clk        (clk),
        .resetn     (resetn),
        .index      (req_fields.index),
        .tag        (req_fields.tag),
        .victim_way (victim_way),
        .lk         (lk.store)
    );

    plru_tree u_plru (
        .clk        (clk),
        .resetn     (resetn),
        .index      (req_fields.index),
        .touch      (touch),
        .touch_way  (touch_way),
        .victim_way (victim_way)
    );

    line_data_ram u_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    miss_controller u_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .req_valid  (req_valid),
        .req_addr   (req_fields),
        .req_strobe (req_strobe),
        .req_wdata  (req_wdata),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .mem_valid  (mem_valid),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready),
        .mem_last   (mem_last),
        .mem_rdata  (mem_rdata),
        .hit_data   (ram_rdata),
        .victim_way (victim_way),
        .lk         (lk.ctrl),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .touch      (touch),
        .touch_way  (touch_way)
    );

endmodule

// ==== hdl/line_data_ram.sv ====
`timescale 1ns/10ps

module line_data_ram (
    input  logic                  clk,
    input  logic                  en,
    input  dcache_pkg::strobe_t   we,
    input  dcache_pkg::ram_addr_t addr,
    input  dcache_pkg::word_t     wdata,
    output dcache_pkg::word_t     rdata
);
    localparam int DEPTH = 2 ** dcache_pkg::RAM_ADDR_BITS;

    dcache_pkg::word_t mem [DEPTH];

    // old word leaves while the new bytes go in
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr];
            for (int b = 0; b < dcache_pkg::WORD_BYTES; b++) begin
                if (we[b]) begin
                    mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== hdl/lookup_if.sv ====
`timescale 1ns/10ps

interface lookup_if;

    // lookup results for the set of the current index
    logic               hit;
    dcache_pkg::way_t   hit_way;
    logic               victim_valid;
    logic               victim_dirty;
    dcache_pkg::tag_t   victim_tag;

    // metadata updates from the controller
    logic               set_dirty;
    logic               refill;
    dcache_pkg::way_t   refill_way;
    logic               clean;

    modport store (
        output hit, hit_way, victim_valid, victim_dirty, victim_tag,
        input  set_dirty, refill, refill_way, clean
    );

    modport ctrl (
        input  hit, hit_way, victim_valid, victim_dirty, victim_tag,
        output set_dirty, refill, refill_way, clean
    );

endinterface

// ==== hdl/miss_controller.sv ====
`timescale 1ns/10ps

module miss_controller (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             req_valid,
    input  dcache_pkg::addr_t                req_addr,
    input  dcache_pkg::strobe_t              req_strobe,
    input  dcache_pkg::word_t                req_wdata,
    output logic                             addr_ok,
    output logic                             data_ok,
    output dcache_pkg::word_t                rdata,
    output logic                             mem_valid,
    output logic                             mem_write,
    output logic [dcache_pkg::ADDR_BITS-1:0] mem_addr,
    output dcache_pkg::word_t                mem_wdata,
    input  logic                             mem_ready,
    input  logic                             mem_last,
    input  dcache_pkg::word_t                mem_rdata,
    input  dcache_pkg::word_t                hit_data,
    input  dcache_pkg::way_t                 victim_way,
    lookup_if.ctrl                           lk,
    output logic                             ram_en,
    output dcache_pkg::strobe_t              ram_we,
    output dcache_pkg::ram_addr_t            ram_addr,
    output dcache_pkg::word_t                ram_wdata,
    output logic                             touch,
    output dcache_pkg::way_t                 touch_way
);
    dcache_pkg::ctrl_state_t          state_q;
    logic [dcache_pkg::OFFSET_BITS:0] cnt_q;
    dcache_pkg::offset_t              beat;
    dcache_pkg::offset_t              line_off;
    dcache_pkg::way_t                 way_q;
    dcache_pkg::tag_t                 vtag_q;
    dcache_pkg::word_t                wb_buf [dcache_pkg::LINE_WORDS];
    logic                             beat_done;

    assign beat      = cnt_q[dcache_pkg::OFFSET_BITS-1:0];
    // bursts wrap from the requested word
    assign line_off  = req_addr.offset + beat;
    assign beat_done = mem_valid && mem_ready;

    assign addr_ok = (state_q == dcache_pkg::IDLE) && req_valid && lk.hit;
    assign rdata   = hit_data;

    assign lk.set_dirty  = addr_ok && (|req_strobe);
    assign lk.refill     = (state_q == dcache_pkg::FETCH) && beat_done && mem_last;
    assign lk.clean      = (state_q == dcache_pkg::WB_SEND) && beat_done && mem_last;
    assign lk.refill_way = way_q;

    assign mem_valid = (state_q == dcache_pkg::WB_SEND) || (state_q == dcache_pkg::FETCH);
    assign mem_write = (state_q == dcache_pkg::WB_SEND);
    assign mem_addr  = {mem_write ? vtag_q : req_addr.tag, req_addr.index, req_addr.offset,
                        {dcache_pkg::ALIGN_BITS{1'b0}}};
    assign mem_wdata = wb_buf[beat];

    always_comb begin
        ram_en    = 1'b0;
        ram_we    = '0;
        ram_addr  = {lk.hit_way, req_addr.index, req_addr.offset};
        ram_wdata = req_wdata;
        touch     = 1'b0;
        touch_way = lk.hit_way;
        case (state_q)
            dcache_pkg::IDLE: begin
                ram_en = addr_ok;
                ram_we = req_strobe;
                touch  = addr_ok;
            end
            dcache_pkg::WB_READ: begin
                ram_en   = !cnt_q[dcache_pkg::OFFSET_BITS];
                ram_addr = {way_q, req_addr.index, line_off};
            end
            dcache_pkg::FETCH: begin
                ram_en    = beat_done;
                ram_we    = '1;
                ram_addr  = {way_q, req_addr.index, line_off};
                ram_wdata = mem_rdata;
                touch     = lk.refill;
                touch_way = way_q;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state_q <= dcache_pkg::IDLE;
            cnt_q   <= '0;
            data_ok <= 1'b0;
        end else begin
            data_ok <= addr_ok;
            case (state_q)
                dcache_pkg::IDLE: begin
                    cnt_q <= '0;
                    if (req_valid && !lk.hit) begin
                        state_q <= (lk.victim_valid && lk.victim_dirty) ? dcache_pkg::WB_READ
                                                                        : dcache_pkg::FETCH;
                    end
                end
                dcache_pkg::WB_READ: begin
                    // one extra cycle for the last RAM read to land
                    if (cnt_q[dcache_pkg::OFFSET_BITS]) begin
                        state_q <= dcache_pkg::WB_SEND;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                dcache_pkg::WB_SEND, dcache_pkg::FETCH: begin
                    if (beat_done) begin
                        cnt_q <= mem_last ? '0 : cnt_q + 1'b1;
                        if (mem_last) begin
                            state_q <= (state_q == dcache_pkg::WB_SEND) ? dcache_pkg::FETCH
                                                                        : dcache_pkg::IDLE;
                        end
                    end
                end
                default: begin
                    state_q <= dcache_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == dcache_pkg::IDLE && req_valid && !lk.hit) begin
            way_q  <= victim_way;
            vtag_q <= lk.victim_tag;
        end
        if (state_q == dcache_pkg::WB_READ && cnt_q != '0) begin
            wb_buf[dcache_pkg::offset_t'(beat - 1'b1)] <= hit_data;
        end
    end

    // the held request must hit once its line is in
    refill_hit: assert property (
        @(posedge clk) disable iff (resetn) lk.refill |=> lk.hit
    ) else $error("held request missed after its refill");

    // a stalled beat keeps its request on the bus
    burst_hold: assert property (
        @(posedge clk) disable iff (resetn)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr)
    ) else $error("memory request dropped before its beat completed");

endmodule

// ==== hdl/plru_tree.sv ====
`timescale 1ns/10ps

module plru_tree (
    input  logic               clk,
    input  logic               resetn,
    input  dcache_pkg::index_t index,
    input  logic               touch,
    input  dcache_pkg::way_t   touch_way,
    output dcache_pkg::way_t   victim_way
);
    dcache_pkg::plru_t bits_q [dcache_pkg::SETS];
    dcache_pkg::plru_t cur;

    assign cur = bits_q[index];

    // root picks the pair and a leaf bit picks the way
    always_comb begin
        if (!cur[0]) begin
            victim_way = cur[1] ? dcache_pkg::way_t'(1) : dcache_pkg::way_t'(0);
        end else begin
            victim_way = cur[2] ? dcache_pkg::way_t'(3) : dcache_pkg::way_t'(2);
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < dcache_pkg::SETS; s++) begin
                bits_q[s] <= '0;
            end
        end else if (touch) begin
            // point the path away from the used way
            if (!touch_way[1]) begin
                bits_q[index][0] <= 1'b1;
                bits_q[index][1] <= !touch_way[0];
            end else begin
                bits_q[index][0] <= 1'b0;
                bits_q[index][2] <= !touch_way[0];
            end
        end
    end

endmodule

// ==== hdl/tag_store.sv ====
`timescale 1ns/10ps

module tag_store (
    input  logic               clk,
    input  logic               resetn,
    input  dcache_pkg::index_t index,
    input  dcache_pkg::tag_t   tag,
    input  dcache_pkg::way_t   victim_way,
    lookup_if.store            lk
);
    logic [dcache_pkg::WAYS-1:0] valid_q [dcache_pkg::SETS];
    logic [dcache_pkg::WAYS-1:0] dirty_q [dcache_pkg::SETS];
    dcache_pkg::tag_t            tag_q   [dcache_pkg::SETS][dcache_pkg::WAYS];
    logic [dcache_pkg::WAYS-1:0] way_hits;

    // all ways compared at once
    always_comb begin
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            way_hits[w] = valid_q[index][w] && (tag_q[index][w] == tag);
        end
    end

    assign lk.hit = |way_hits;

    always_comb begin
        lk.hit_way = '0;
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            if (way_hits[w]) begin
                lk.hit_way = dcache_pkg::way_t'(w);
            end
        end
    end

    // metadata of the line the PLRU would replace
    assign lk.victim_valid = valid_q[index][victim_way];
    assign lk.victim_dirty = dirty_q[index][victim_way];
    assign lk.victim_tag   = tag_q[index][victim_way];

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < dcache_pkg::SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            if (lk.refill) begin
                valid_q[index][lk.refill_way] <= 1'b1;
                dirty_q[index][lk.refill_way] <= 1'b0;
            end else if (lk.clean) begin
                // memory now holds the written-back victim
                dirty_q[index][lk.refill_way] <= 1'b0;
            end else if (lk.set_dirty) begin
                dirty_q[index][lk.hit_way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lk.refill) begin
            tag_q[index][lk.refill_way] <= tag;
        end
    end

    // refills only ever land on a miss, so a tag lives in one way at most
    one_way_hit: assert property (
        @(posedge clk) disable iff (resetn) $onehot0(way_hits)
    ) else $error("tag matched in more than one way");

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module dcache_tb -Mdir "$build_dir" -o dcache_sim -f dcache.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/dcache_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
